/* design/s1c88_bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module s1c88_bus_arbiter
(
    input logic clk,
    input logic reset,
    s1c88_mem_if.slave fetch_bus,
    s1c88_mem_if.slave exec_bus,
    output logic mem_req,
    output logic mem_write,
    output s1c88_pkg::addr_t mem_addr,
    output s1c88_pkg::byte_t mem_wdata,
    input logic mem_ack,
    input s1c88_pkg::byte_t mem_rdata
);
    logic grant_valid;
    logic grant_exec;
    logic sel_exec;
    logic sel_req;

    // with no grant held the sequencer goes first
    assign sel_exec = grant_valid ? grant_exec : exec_bus.req;
    assign sel_req = sel_exec ? exec_bus.req : fetch_bus.req;

    assign mem_req = sel_req;
    assign mem_write = sel_exec ? exec_bus.write : fetch_bus.write;
    assign mem_addr = sel_exec ? exec_bus.addr : fetch_bus.addr;
    assign mem_wdata = sel_exec ? exec_bus.wdata : fetch_bus.wdata;

    // the waiting master only sees ack low
    assign exec_bus.ack = sel_exec && mem_ack;
    assign fetch_bus.ack = !sel_exec && mem_ack;
    assign exec_bus.rdata = sel_exec ? mem_rdata : '0;
    assign fetch_bus.rdata = sel_exec ? '0 : mem_rdata;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            grant_valid <= 1'b0;
            grant_exec <= 1'b0;
        end
        else if (!grant_valid)
        begin
            if (sel_req)
            begin
                grant_valid <= 1'b1;
                grant_exec <= sel_exec;
            end
        end
        // release once req and ack are both back low
        else if (!sel_req && !mem_ack)
            grant_valid <= 1'b0;
    end

endmodule

`default_nettype wire

/* design/s1c88_core.sv */
`timescale 1ns/100ps
`default_nettype none

module s1c88_core
(
    input logic clk,
    input logic reset,
    output logic mem_req,
    output logic mem_write,
    output s1c88_pkg::addr_t mem_addr,
    output s1c88_pkg::byte_t mem_wdata,
    input logic mem_ack,
    input s1c88_pkg::byte_t mem_rdata
);
    // each stage owns one memory port, the arbiter merges them
    s1c88_mem_if fetch_bus ();
    s1c88_mem_if exec_bus ();
    s1c88_instr_if instr ();

    s1c88_fetch fetch_inst
    (
        .clk   (clk),
        .reset (reset),
        .mem   (fetch_bus.master),
        .instr (instr.master)
    );

    s1c88_microseq microseq_inst
    (
        .clk   (clk),
        .reset (reset),
        .instr (instr.slave),
        .mem   (exec_bus.master)
    );

    s1c88_bus_arbiter bus_arbiter_inst
    (
        .clk       (clk),
        .reset     (reset),
        .fetch_bus (fetch_bus.slave),
        .exec_bus  (exec_bus.slave),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* design/s1c88_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module s1c88_fetch
(
    input logic clk,
    input logic reset,
    s1c88_mem_if.master mem,
    s1c88_instr_if.master instr
);
    import s1c88_pkg::*;

    fetch_state_t state;
    pc_t pc;
    logic mem_req;
    logic instr_req;
    logic mem_done;
    logic first_operand;
    logic [1:0] operands_left;
    byte_t opcode;
    byte_t op1;
    byte_t op2;

    // number of operand bytes after each opcode
    function automatic logic [1:0] operand_count(input byte_t op);
        case (op)
            OP_LD_A_BRLL, OP_LD_BRLL_A, OP_LD_BR_IMM:
                return 2'd1;
            OP_LD_BRLL_IMM, OP_OR_BRLL_IMM:
                return 2'd2;
            default:
                return 2'd0;
        endcase
    endfunction

    assign mem_done = mem_req && mem.ack;
    assign first_operand = (operands_left == operand_count(opcode));

    always_comb
    begin
        case (state)
            FETCH_VEC_LO:
                mem.addr = RESET_VECTOR_LO;
            FETCH_VEC_HI:
                mem.addr = RESET_VECTOR_HI;
            default:
                mem.addr = {{(ADDR_W-CODE_ADDR_W){1'b0}}, pc[CODE_ADDR_W-1:0]};
        endcase
    end

    // fetch only reads
    assign mem.req = mem_req;
    assign mem.write = 1'b0;
    assign mem.wdata = '0;

    assign instr.req = instr_req;
    assign instr.opcode = opcode;
    assign instr.op1 = op1;
    assign instr.op2 = op2;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= FETCH_VEC_LO;
            pc <= '0;
            mem_req <= 1'b0;
            instr_req <= 1'b0;
            operands_left <= 2'd0;
        end
        else
        begin
            // a new read waits for the previous ack to fall
            if (mem_done)
                mem_req <= 1'b0;
            else if (!mem_req && !mem.ack && state != FETCH_HANDOFF)
                mem_req <= 1'b1;

            case (state)
                FETCH_VEC_LO:
                    if (mem_done)
                    begin
                        pc[BYTE_W-1:0] <= mem.rdata;
                        state <= FETCH_VEC_HI;
                    end
                FETCH_VEC_HI:
                    if (mem_done)
                    begin
                        pc[PC_W-1:BYTE_W] <= mem.rdata;
                        state <= FETCH_OPCODE;
                    end
                FETCH_OPCODE:
                    if (mem_done)
                    begin
                        pc <= pc + 1'b1;
                        operands_left <= operand_count(mem.rdata);
                        if (operand_count(mem.rdata) == 2'd0)
                            state <= FETCH_HANDOFF;
                        else
                            state <= FETCH_OPERAND;
                    end
                FETCH_OPERAND:
                    if (mem_done)
                    begin
                        pc <= pc + 1'b1;
                        operands_left <= operands_left - 1'b1;
                        if (operands_left == 2'd1)
                            state <= FETCH_HANDOFF;
                    end
                FETCH_HANDOFF:
                    if (!instr_req && !instr.ack)
                        instr_req <= 1'b1;
                    else if (instr_req && instr.ack)
                    begin
                        // sequencer has the bytes, start on the next opcode
                        instr_req <= 1'b0;
                        state <= FETCH_OPCODE;
                    end
                default:
                    state <= FETCH_VEC_LO;
            endcase
        end
    end

    // ll lands in op1, the immediate is always the last byte
    always_ff @(posedge clk)
    begin
        if (mem_done && state == FETCH_OPCODE)
            opcode <= mem.rdata;
        if (mem_done && state == FETCH_OPERAND)
        begin
            op2 <= mem.rdata;
            if (first_operand)
                op1 <= mem.rdata;
        end
    end

endmodule

`default_nettype wire

/* design/s1c88_if.sv */
`timescale 1ns/100ps
`default_nettype none

// one four-phase memory port
interface s1c88_mem_if;
    import s1c88_pkg::*;

    logic req;
    logic write;
    addr_t addr;
    byte_t wdata;
    logic ack;
    byte_t rdata;

    modport master
    (
        output req, write, addr, wdata,
        input ack, rdata
    );

    modport slave
    (
        input req, write, addr, wdata,
        output ack, rdata
    );
endinterface

// instruction hand-off from fetch to the sequencer
interface s1c88_instr_if;
    import s1c88_pkg::*;

    logic req;
    byte_t opcode;
    byte_t op1;
    byte_t op2;
    logic ack;

    modport master
    (
        output req, opcode, op1, op2,
        input ack
    );

    modport slave
    (
        input req, opcode, op1, op2,
        output ack
    );
endinterface

`default_nettype wire

/* design/s1c88_microcode.svh */
`ifndef S1C88_MICROCODE_SVH
`define S1C88_MICROCODE_SVH

// packs the fields of one micro step
function automatic micro_word_t micro_step
(
    input micro_type_t step_type,
    input micro_mov_t src,
    input micro_mov_t dst,
    input micro_alu_t alu_op,
    input logic last
);
    return {step_type, src, dst, alu_op, last, {MICRO_SPARE_W{1'b0}}};
endfunction

// micro rom, unused slots behave like a one-step nop
function automatic micro_word_t micro_rom_entry(input micro_addr_t addr);
    case (addr)
        UADDR_LD_A:
            return micro_step(MICRO_TYPE_READ, MICRO_MOV_MEM, MICRO_MOV_A, MICRO_ALU_NONE, 1'b1);
        UADDR_ST_A:
            return micro_step(MICRO_TYPE_WRITE, MICRO_MOV_A, MICRO_MOV_NONE, MICRO_ALU_NONE, 1'b1);
        UADDR_LD_BR:
            return micro_step(MICRO_TYPE_MISC, MICRO_MOV_IMM, MICRO_MOV_BR, MICRO_ALU_NONE, 1'b1);
        UADDR_ST_IMM:
            return micro_step(MICRO_TYPE_WRITE, MICRO_MOV_IMM, MICRO_MOV_NONE, MICRO_ALU_NONE, 1'b1);
        // read old byte, or in #nn, write it back
        UADDR_OR_IMM:
            return micro_step(MICRO_TYPE_READ, MICRO_MOV_MEM, MICRO_MOV_ALU_R, MICRO_ALU_OR, 1'b0);
        UADDR_OR_IMM + 5'd1:
            return micro_step(MICRO_TYPE_WRITE, MICRO_MOV_ALU_R, MICRO_MOV_NONE, MICRO_ALU_NONE, 1'b1);
        default:
            return micro_step(MICRO_TYPE_MISC, MICRO_MOV_NONE, MICRO_MOV_NONE, MICRO_ALU_NONE, 1'b1);
    endcase
endfunction

// opcode to micro program entry
function automatic micro_addr_t trans_entry(input byte_t opcode);
    case (opcode)
        OP_LD_A_BRLL:   return UADDR_LD_A;
        OP_LD_BRLL_A:   return UADDR_ST_A;
        OP_LD_BR_IMM:   return UADDR_LD_BR;
        OP_LD_BRLL_IMM: return UADDR_ST_IMM;
        OP_OR_BRLL_IMM: return UADDR_OR_IMM;
        default:        return UADDR_NOP;
    endcase
endfunction

`endif

/* design/s1c88_microseq.sv */
`timescale 1ns/100ps
`default_nettype none

module s1c88_microseq
(
    input logic clk,
    input logic reset,
    s1c88_instr_if.slave instr,
    s1c88_mem_if.master mem
);
    import s1c88_pkg::*;

    `include "s1c88_microcode.svh"

    micro_addr_t trans_table [TRANS_DEPTH];
    micro_word_t micro_rom [MICRO_ROM_DEPTH];

    exec_state_t state;
    micro_addr_t upc;
    micro_word_t micro_word;
    micro_type_t micro_type;
    micro_mov_t micro_src;
    micro_mov_t micro_dst;
    micro_alu_t micro_alu;
    logic micro_last;
    logic instr_ack;
    logic mem_req;
    logic bus_done;
    logic step_commit;
    logic accept;
    byte_t a_reg;
    byte_t br_reg;
    byte_t op1_reg;
    byte_t op2_reg;
    byte_t alu_reg;
    byte_t src_val;
    byte_t alu_result;

    for (genvar i = 0; i < TRANS_DEPTH; i++)
    begin : g_trans
        assign trans_table[i] = trans_entry(byte_t'(i));
    end

    for (genvar i = 0; i < MICRO_ROM_DEPTH; i++)
    begin : g_rom
        assign micro_rom[i] = micro_rom_entry(micro_addr_t'(i));
    end

    assign micro_word = micro_rom[upc];
    assign micro_type = micro_word[MICRO_TYPE_LSB +: MICRO_TYPE_W];
    assign micro_src = micro_word[MICRO_SRC_LSB +: MICRO_MOV_W];
    assign micro_dst = micro_word[MICRO_DST_LSB +: MICRO_MOV_W];
    assign micro_alu = micro_word[MICRO_ALU_LSB +: MICRO_ALU_W];
    assign micro_last = micro_word[MICRO_LAST_BIT];

    always_comb
    begin
        case (micro_src)
            MICRO_MOV_A:     src_val = a_reg;
            MICRO_MOV_BR:    src_val = br_reg;
            MICRO_MOV_IMM:   src_val = op2_reg;
            MICRO_MOV_MEM:   src_val = mem.rdata;
            MICRO_MOV_ALU_R: src_val = alu_reg;
            default:         src_val = '0;
        endcase
    end

    // the alu sits in the move path, or takes #nn as its second input
    assign alu_result = (micro_alu == MICRO_ALU_OR) ? (src_val | op2_reg) : src_val;

    assign accept = (state == EXEC_IDLE) && instr.req && !instr_ack;
    assign bus_done = mem_req && mem.ack;
    assign step_commit = (state == EXEC_STEP && micro_type == MICRO_TYPE_MISC) ||
                         (state == EXEC_BUS && bus_done);

    assign instr.ack = instr_ack;
    assign mem.req = mem_req;
    assign mem.write = (micro_type == MICRO_TYPE_WRITE);
    assign mem.addr = {{(ADDR_W-2*BYTE_W){1'b0}}, br_reg, op1_reg};
    assign mem.wdata = src_val;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= EXEC_IDLE;
            upc <= '0;
            instr_ack <= 1'b0;
            mem_req <= 1'b0;
            a_reg <= '0;
            br_reg <= '0;
        end
        else
        begin
            if (instr_ack && !instr.req)
                instr_ack <= 1'b0;

            case (state)
                EXEC_IDLE:
                    if (accept)
                    begin
                        instr_ack <= 1'b1;
                        upc <= trans_table[instr.opcode];
                        state <= EXEC_STEP;
                    end
                EXEC_STEP:
                    if (micro_type != MICRO_TYPE_MISC && !mem.ack)
                    begin
                        mem_req <= 1'b1;
                        state <= EXEC_BUS;
                    end
                EXEC_BUS:
                    if (bus_done)
                        mem_req <= 1'b0;
                // wait for the hand-off to finish before taking the next one
                EXEC_DONE:
                    if (!instr_ack)
                        state <= EXEC_IDLE;
                default:
                    state <= EXEC_IDLE;
            endcase

            if (step_commit)
            begin
                case (micro_dst)
                    MICRO_MOV_A:  a_reg <= alu_result;
                    MICRO_MOV_BR: br_reg <= alu_result;
                    default:      ;
                endcase
                if (micro_last)
                    state <= EXEC_DONE;
                else
                begin
                    upc <= upc + 1'b1;
                    state <= EXEC_STEP;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op1_reg <= instr.op1;
            op2_reg <= instr.op2;
        end
        if (step_commit && micro_dst == MICRO_MOV_ALU_R)
            alu_reg <= alu_result;
    end

endmodule

`default_nettype wire

/* design/s1c88_pkg.sv */
`default_nettype none

package s1c88_pkg;

    localparam int ADDR_W = 24;
    localparam int BYTE_W = 8;
    localparam int PC_W = 16;
    localparam int CODE_ADDR_W = 15;
    localparam int MICRO_ADDR_W = 5;
    localparam int MICRO_WORD_W = 16;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [PC_W-1:0] pc_t;
    typedef logic [MICRO_ADDR_W-1:0] micro_addr_t;
    typedef logic [MICRO_WORD_W-1:0] micro_word_t;

    localparam int MICRO_ROM_DEPTH = 32;
    localparam int TRANS_DEPTH = 256;

    // micro word layout, msb first: type, src, dst, alu op, last, spare
    localparam int MICRO_TYPE_W = 2;
    localparam int MICRO_MOV_W = 3;
    localparam int MICRO_ALU_W = 2;
    localparam int MICRO_SPARE_W = 5;
    localparam int MICRO_TYPE_LSB = 14;
    localparam int MICRO_SRC_LSB = 11;
    localparam int MICRO_DST_LSB = 8;
    localparam int MICRO_ALU_LSB = 6;
    localparam int MICRO_LAST_BIT = 5;

    typedef logic [MICRO_TYPE_W-1:0] micro_type_t;
    typedef logic [MICRO_MOV_W-1:0] micro_mov_t;
    typedef logic [MICRO_ALU_W-1:0] micro_alu_t;

    localparam micro_type_t MICRO_TYPE_MISC = 2'd0;
    localparam micro_type_t MICRO_TYPE_READ = 2'd1;
    localparam micro_type_t MICRO_TYPE_WRITE = 2'd2;

    localparam micro_mov_t MICRO_MOV_NONE = 3'd0;
    localparam micro_mov_t MICRO_MOV_A = 3'd1;
    localparam micro_mov_t MICRO_MOV_BR = 3'd2;
    localparam micro_mov_t MICRO_MOV_IMM = 3'd3;
    localparam micro_mov_t MICRO_MOV_MEM = 3'd4;
    localparam micro_mov_t MICRO_MOV_ALU_R = 3'd5;

    localparam micro_alu_t MICRO_ALU_NONE = 2'd0;
    localparam micro_alu_t MICRO_ALU_OR = 2'd1;

    // entry points of the micro programs
    localparam micro_addr_t UADDR_NOP = 5'd0;
    localparam micro_addr_t UADDR_LD_A = 5'd1;
    localparam micro_addr_t UADDR_ST_A = 5'd2;
    localparam micro_addr_t UADDR_LD_BR = 5'd3;
    localparam micro_addr_t UADDR_ST_IMM = 5'd4;
    localparam micro_addr_t UADDR_OR_IMM = 5'd5;

    localparam byte_t OP_LD_A_BRLL = 8'h44;
    localparam byte_t OP_LD_BRLL_A = 8'h78;
    localparam byte_t OP_LD_BR_IMM = 8'hB4;
    localparam byte_t OP_LD_BRLL_IMM = 8'hDD;
    localparam byte_t OP_OR_BRLL_IMM = 8'hD9;

    localparam addr_t RESET_VECTOR_LO = 24'h000000;
    localparam addr_t RESET_VECTOR_HI = 24'h000001;

    typedef enum logic [2:0] {
        FETCH_VEC_LO,
        FETCH_VEC_HI,
        FETCH_OPCODE,
        FETCH_OPERAND,
        FETCH_HANDOFF
    } fetch_state_t;

    typedef enum logic [1:0] {
        EXEC_IDLE,
        EXEC_STEP,
        EXEC_BUS,
        EXEC_DONE
    } exec_state_t;

endpackage

`default_nettype wire

/* filelist.f */
+incdir+design
+incdir+tb
design/s1c88_pkg.sv
design/s1c88_if.sv
design/s1c88_fetch.sv
design/s1c88_microseq.sv
design/s1c88_bus_arbiter.sv
design/s1c88_core.sv
tb/s1c88_tb.sv

/* tb/s1c88_ref_model.svh */
`ifndef S1C88_REF_MODEL_SVH
`define S1C88_REF_MODEL_SVH

logic [31:0] rng_state = 32'h1337;

// xorshift32, one step per call
function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// bytes that follow each opcode in the kept instruction set
function automatic int operand_bytes(input byte_t op);
    case (op)
        OP_LD_A_BRLL, OP_LD_BRLL_A, OP_LD_BR_IMM:
            return 1;
        OP_LD_BRLL_IMM, OP_OR_BRLL_IMM:
            return 2;
        default:
            return 0;
    endcase
endfunction

// initial contents of the data area
function automatic byte_t data_fill(input logic [15:0] addr);
    return addr[15:8] ^ {addr[6:0], addr[7]} ^ 8'h3C;
endfunction

// unused code space holds one-byte fillers only
function automatic byte_t code_fill(input logic [15:0] addr);
    byte_t op;
    op = addr[7:0] ^ {1'b0, addr[14:8]} ^ 8'hA7;
    if (operand_bytes(op) != 0)
        op = op ^ 8'h01;
    return op;
endfunction

// small ll range so that loads often hit earlier stores
function automatic void build_random_program(input int length);
    byte_t op;
    prog_q.delete();
    prog_q.push_back(OP_LD_BR_IMM);
    prog_q.push_back(8'h80 | byte_t'(next_random() & 3));
    for (int i = 1; i < length; i++)
    begin
        case (next_random() % 6)
            0: op = OP_LD_A_BRLL;
            1: op = OP_LD_BRLL_A;
            2: op = OP_LD_BR_IMM;
            3: op = OP_LD_BRLL_IMM;
            4: op = OP_OR_BRLL_IMM;
            default: op = byte_t'(next_random());
        endcase
        while (op != OP_LD_BR_IMM && operand_bytes(op) == 0 && next_random() % 7 == 0)
            op = op + 1'b1;
        prog_q.push_back(op);
        // BR stays above the code range
        if (op == OP_LD_BR_IMM)
            prog_q.push_back(8'h80 | byte_t'(next_random() & 3));
        else if (operand_bytes(op) > 0)
            prog_q.push_back(byte_t'(next_random() % 16));
        if (operand_bytes(op) == 2)
            prog_q.push_back(byte_t'(next_random()));
    end
endfunction

// instruction level model, lists every write in program order
function automatic void compute_expected_writes();
    byte_t a;
    byte_t br;
    byte_t op;
    byte_t ll;
    byte_t nn;
    byte_t value;
    logic [15:0] da;
    byte_t written [int];
    int i;
    a = 8'h00;
    br = 8'h00;
    i = 0;
    exp_addr_q.delete();
    exp_data_q.delete();
    while (i < prog_q.size())
    begin
        op = prog_q[i];
        ll = (operand_bytes(op) > 0) ? prog_q[i + 1] : 8'h00;
        nn = prog_q[i + operand_bytes(op)];
        da = {br, ll};
        value = written.exists(da) ? written[da] : data_fill(da);
        case (op)
            OP_LD_A_BRLL: a = value;
            OP_LD_BR_IMM: br = nn;
            OP_LD_BRLL_A: value = a;
            OP_LD_BRLL_IMM: value = nn;
            OP_OR_BRLL_IMM: value = value | nn;
            default: ;
        endcase
        if (op == OP_LD_BRLL_A || op == OP_LD_BRLL_IMM || op == OP_OR_BRLL_IMM)
        begin
            written[da] = value;
            exp_addr_q.push_back({8'h00, da});
            exp_data_q.push_back(value);
        end
        i = i + 1 + operand_bytes(op);
    end
endfunction

`endif

/* tb/s1c88_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module s1c88_tb;
    import s1c88_pkg::*;

    logic clk;
    logic reset;
    logic mem_req;
    logic mem_write;
    addr_t mem_addr;
    byte_t mem_wdata;
    logic mem_ack;
    byte_t mem_rdata;

    byte_t mem [65536];
    byte_t prog_q [$];
    addr_t exp_addr_q [$];
    byte_t exp_data_q [$];
    addr_t obs_addr_q [$];
    byte_t obs_data_q [$];
    event write_seen;
    string test_name;
    addr_t next_code_addr;
    int read_index;
    int code_reads;
    int write_count;
    int cycle_count;
    int cycle_limit;

    `include "s1c88_ref_model.svh"

    s1c88_core s1c88_core_inst
    (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        stop_with_failure();
    endtask

    // vector bytes first, then code reads must run in order from the vector
    task automatic check_read_address(input addr_t addr);
        if (read_index < 2)
            assert (addr == addr_t'(read_index))
            else report_mismatch("reset vector read address", read_index, addr);
        else if (read_index == 2 || !addr[15])
        begin
            assert (addr == next_code_addr)
            else report_mismatch("code fetch address", next_code_addr, addr);
            next_code_addr = (next_code_addr + 1'b1) & 24'h007FFF;
            code_reads++;
        end
        read_index++;
    endtask

    task automatic serve_transfer(input addr_t addr, input logic write, input byte_t wdata);
        if (write)
        begin
            mem[addr[15:0]] = wdata;
            obs_addr_q.push_back(addr);
            obs_data_q.push_back(wdata);
            -> write_seen;
        end
        else
        begin
            mem_rdata = mem[addr[15:0]];
            check_read_address(addr);
        end
    endtask

    // memory model, ack after 0 to 3 idle cycles
    initial
    begin
        addr_t addr;
        logic write;
        byte_t wdata;
        int latency;
        forever
        begin
            @(negedge clk);
            if (mem_req)
            begin
                addr = mem_addr;
                write = mem_write;
                wdata = mem_wdata;
                latency = next_random() % 4;
                repeat (latency) @(posedge clk);
                @(posedge clk);
                #2;
                if (!reset)
                    serve_transfer(addr, write, wdata);
                mem_ack = 1'b1;
                do
                    @(negedge clk);
                while (mem_req);
                @(posedge clk);
                #2;
                mem_ack = 1'b0;
            end
        end
    end

    // observed writes against the reference list, in order
    initial
    begin
        addr_t addr;
        byte_t data;
        forever
        begin
            @(write_seen);
            while (obs_addr_q.size() > 0)
            begin
                addr = obs_addr_q.pop_front();
                data = obs_data_q.pop_front();
                assert (write_count < exp_addr_q.size())
                else
                begin
                    $display("%s: write of %0h to %0h when no write was expected",
                             test_name, data, addr);
                    stop_with_failure();
                end
                assert (addr == exp_addr_q[write_count])
                else report_mismatch("write address", exp_addr_q[write_count], addr);
                assert (data == exp_data_q[write_count])
                else report_mismatch("write data", exp_data_q[write_count], data);
                write_count++;
            end
        end
    end

    initial
    begin
        forever
        begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > cycle_limit)
            begin
                $display("%s: the core stopped making progress after %0d cycles",
                         test_name, cycle_count);
                stop_with_failure();
            end
        end
    end

    // loads prog_q behind the given vector and runs it from reset
    task automatic run_program(input string name, input logic [15:0] vector);
        int count;
        int pos;
        test_name = name;
        count = 0;
        pos = 0;
        while (pos < prog_q.size())
        begin
            pos = pos + 1 + operand_bytes(prog_q[pos]);
            count++;
        end
        cycle_count = 0;
        cycle_limit = 400 * count + 1000;
        @(posedge clk);
        #2;
        reset = 1'b1;
        repeat (10) @(posedge clk);
        for (int a = 0; a < 65536; a++)
            mem[a] = (a < 32768) ? code_fill(16'(a)) : data_fill(16'(a));
        mem[0] = vector[7:0];
        mem[1] = vector[15:8];
        for (int i = 0; i < prog_q.size(); i++)
            mem[(int'(vector[14:0]) + i) % 32768] = prog_q[i];
        compute_expected_writes();
        write_count = 0;
        read_index = 0;
        code_reads = 0;
        next_code_addr = {9'b0, vector[14:0]};
        #2;
        reset = 1'b0;
        // a fetch two bytes past the end means the last instruction retired
        while (code_reads < prog_q.size() + 2)
            @(posedge clk);
        assert (write_count == exp_addr_q.size())
        else report_mismatch("write count", exp_addr_q.size(), write_count);
    endtask

    initial
    begin
        logic [31:0] r;
        reset = 1'b1;
        mem_ack = 1'b0;
        mem_rdata = 8'h00;
        write_count = 0;
        read_index = 0;
        code_reads = 0;
        cycle_count = 0;
        cycle_limit = 1000;
        next_code_addr = '0;
        test_name = "startup";

        // bit 15 of the vector is set and must not reach the bus
        prog_q = '{8'h00, 8'h01};
        run_program("reset_vector", 16'hC1F0);

        prog_q = '{OP_LD_BR_IMM, 8'h9A, OP_LD_BRLL_IMM, 8'h3C, 8'h5E};
        run_program("immediate_store", 16'h0200);

        prog_q = '{OP_LD_BR_IMM, 8'hA0, OP_LD_A_BRLL, 8'h10, OP_LD_BRLL_A, 8'h11};
        run_program("load_store_a", 16'h0480);

        prog_q = '{OP_LD_BR_IMM, 8'hB7, OP_OR_BRLL_IMM, 8'h42, 8'h81};
        run_program("read_modify_write", 16'h1234);

        prog_q = '{8'h00, 8'hFF, 8'h12, 8'h45, OP_LD_BR_IMM, 8'hC0, 8'h03,
                   OP_LD_BRLL_IMM, 8'h01, 8'h77, 8'h9E};
        run_program("unknown_opcodes", 16'h2FF0);

        for (int n = 0; n < 4; n++)
        begin
            build_random_program(50);
            r = next_random();
            run_program($sformatf("random_%0d", n), {r[15], 15'(16'h0100 + r[13:0])});
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
